// ==== Makefile ====
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -j 0
SIM_ARGS   ?= +verilator+error+limit+100
TOP        ?= tb_mem_subsystem
FLIST      ?= vlog.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   := *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

# the run itself never decides the result, the log search does
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	grep -qxF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== data_sram.sv ====
`timescale 1ns/1ps

module data_sram #(
	parameter int DMEM_AW = 8
) (
	input  logic                            clk,
	input  logic                            en_i,
	input  logic [mips_pipe_pkg::LANES-1:0] we_i,
	input  logic [DMEM_AW-1:0]              addr_i,
	input  logic [mips_pipe_pkg::XLEN-1:0]  wdata_i,
	output logic [mips_pipe_pkg::XLEN-1:0]  rdata_o
);
	import mips_pipe_pkg::*;

	localparam int DEPTH = 2 ** DMEM_AW;

	logic [XLEN-1:0] mem [DEPTH];
	logic [XLEN-1:0] merged;

	// old word with the enabled lanes replaced
	always_comb begin
		merged = mem[addr_i];
		for (int n = 0; n < LANES; n++) begin
			if (we_i[n]) begin
				merged[BYTE_W*n +: BYTE_W] = wdata_i[BYTE_W*n +: BYTE_W];
			end
		end
	end

	// write-first; rdata holds while disabled
	always_ff @(posedge clk) begin
		if (en_i) begin
			if (|we_i) begin
				mem[addr_i] <= merged;
			end
			rdata_o <= merged;
		end
	end

endmodule

// ==== mem_access.sv ====
`timescale 1ns/1ps

module mem_access #(
	parameter int DMEM_AW = 8
) (
	input  logic                                 clk,
	input  logic                                 rst_n_i,
	input  logic                                 stall_i,
	input  mips_mem_pkg::memop_e                 ex_memop_i,
	input  logic [mips_pipe_pkg::XLEN-1:0]       ex_addr_i,
	input  logic [mips_pipe_pkg::XLEN-1:0]       ex_store_data_i,
	input  logic [mips_pipe_pkg::XLEN-1:0]       ex_inst_i,
	input  logic [mips_pipe_pkg::XLEN-1:0]       ex_pc_i,
	input  logic                                 ex_inslot_i,
	input  logic [mips_pipe_pkg::REG_AW-1:0]     ex_waddr_i,
	input  logic [mips_pipe_pkg::XLEN-1:0]       ex_wdata_i,
	input  logic [mips_pipe_pkg::LANES-1:0]      ex_wren_i,
	input  logic                                 ex_nofwd_i,
	input  logic                                 ex_c0_ren_i,
	input  logic [mips_pipe_pkg::XLEN-1:0]       ex_c0data_i,
	output logic                                 sram_en_o,
	output logic [mips_pipe_pkg::LANES-1:0]      sram_we_o,
	output logic [DMEM_AW-1:0]                   sram_addr_o,
	output logic [mips_pipe_pkg::XLEN-1:0]       sram_wdata_o,
	output mips_mem_pkg::memop_e                 mem_memop_o,
	output logic [1:0]                           mem_addr_low_o,
	output logic [mips_pipe_pkg::XLEN-1:0]       mem_inst_o,
	output logic [mips_pipe_pkg::XLEN-1:0]       mem_pc_o,
	output logic                                 mem_inslot_o,
	output logic [mips_pipe_pkg::REG_AW-1:0]     mem_waddr_o,
	output logic [mips_pipe_pkg::XLEN-1:0]       mem_wdata_o,
	output logic [mips_pipe_pkg::LANES-1:0]      mem_wren_o,
	output logic                                 mem_nofwd_o,
	output logic                                 mem_c0_ren_o,
	output logic [mips_pipe_pkg::XLEN-1:0]       mem_c0data_o
);
	import mips_pipe_pkg::*;
	import mips_mem_pkg::*;

	logic [1:0]       k;
	logic [LANES-1:0] store_be;
	logic [XLEN-1:0]  store_data;

	assign k = ex_addr_i[1:0];

	// lane enables and lane-aligned data per store flavour
	always_comb begin
		store_be   = '0;
		store_data = ex_store_data_i;
		case (ex_memop_i)
			MOP_SB: begin
				store_be   = {{(LANES-1){1'b0}}, 1'b1} << k;
				store_data = {LANES{ex_store_data_i[7:0]}};
			end
			MOP_SH: begin
				store_be   = {{(LANES-2){1'b0}}, 2'b11} << k;
				store_data = {2{ex_store_data_i[15:0]}};
			end
			MOP_SW: store_be = {LANES{1'b1}};
			// swl fills lanes 0..k from the top of the register
			MOP_SWL: begin
				store_be   = {LANES{1'b1}} >> ~k;
				store_data = ex_store_data_i >> {~k, 3'b000};
			end
			// swr fills lanes k..3 from the bottom of the register
			MOP_SWR: begin
				store_be   = {LANES{1'b1}} << k;
				store_data = ex_store_data_i << {k, 3'b000};
			end
			default: ;
		endcase
	end

	// SRAM request goes out in the same cycle as the EX fields
	assign sram_en_o    = ~stall_i & (is_load(ex_memop_i) | is_store(ex_memop_i));
	assign sram_we_o    = stall_i ? '0 : store_be;
	assign sram_addr_o  = ex_addr_i[ADDR_LSB +: DMEM_AW];
	assign sram_wdata_o = store_data;

	// EX/MEM boundary
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			mem_memop_o    <= MOP_NONE;
			mem_addr_low_o <= '0;
			mem_inst_o     <= '0;
			mem_pc_o       <= '0;
			mem_inslot_o   <= 1'b0;
			mem_waddr_o    <= '0;
			mem_wdata_o    <= '0;
			mem_wren_o     <= '0;
			mem_nofwd_o    <= 1'b0;
			mem_c0_ren_o   <= 1'b0;
			mem_c0data_o   <= '0;
		end else if (!stall_i) begin
			mem_memop_o    <= ex_memop_i;
			mem_addr_low_o <= k;
			mem_inst_o     <= ex_inst_i;
			mem_pc_o       <= ex_pc_i;
			mem_inslot_o   <= ex_inslot_i;
			mem_waddr_o    <= ex_waddr_i;
			mem_wdata_o    <= ex_wdata_i;
			mem_wren_o     <= ex_wren_i;
			mem_nofwd_o    <= ex_nofwd_i;
			mem_c0_ren_o   <= ex_c0_ren_i;
			mem_c0data_o   <= ex_c0data_i;
		end
	end

endmodule

// ==== mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage (
	input  logic                             clk,
	input  logic                             rst_n_i,
	input  logic                             stall_i,
	input  logic                             flush_i,
	input  logic [mips_pipe_pkg::XLEN-1:0]   memdata_i,
	input  mips_mem_pkg::memop_e             mem_memop_i,
	input  logic [1:0]                       mem_addr_low_i,
	input  logic [mips_pipe_pkg::XLEN-1:0]   mem_inst_i,
	input  logic [mips_pipe_pkg::XLEN-1:0]   mem_pc_i,
	input  logic                             mem_inslot_i,
	input  logic [mips_pipe_pkg::REG_AW-1:0] mem_waddr_i,
	input  logic [mips_pipe_pkg::XLEN-1:0]   mem_wdata_i,
	input  logic [mips_pipe_pkg::LANES-1:0]  mem_wren_i,
	input  logic                             mem_nofwd_i,
	input  logic                             mem_c0_ren_i,
	input  logic [mips_pipe_pkg::XLEN-1:0]   mem_c0data_i,
	output logic [mips_pipe_pkg::XLEN-1:0]   wb_inst_o,
	output logic                             wb_inslot_o,
	output logic                             wb_is_mem_o,
	output logic [mips_pipe_pkg::REG_AW-1:0] wb_waddr_o,
	output logic [mips_pipe_pkg::XLEN-1:0]   wb_wdata_o,
	output logic [mips_pipe_pkg::LANES-1:0]  wb_wren_o,
	output logic [mips_pipe_pkg::XLEN-1:0]   wb_pc_o,
	output logic [mips_pipe_pkg::XLEN-1:0]   mem_wdata_bp_o,
	output logic                             mem_nofwd_bp_o
);
	import mips_pipe_pkg::*;
	import mips_mem_pkg::*;

	logic [1:0]       k;
	logic [7:0]       byte_sel;
	logic [15:0]      half_sel;
	logic [XLEN-1:0]  load_data;
	logic [LANES-1:0] load_wren;
	logic             ld;
	logic [XLEN-1:0]  wdata_next;
	logic [LANES-1:0] wren_next;

	assign k        = mem_addr_low_i;
	assign byte_sel = memdata_i[{k, 3'b000} +: 8];
	assign half_sel = memdata_i[{k[1], 4'b0000} +: 16];
	assign ld       = is_load(mem_memop_i);

	// load extraction; partial loads also narrow the lane mask
	always_comb begin
		load_data = memdata_i;
		load_wren = {LANES{1'b1}};
		case (mem_memop_i)
			MOP_LB:  load_data = {{(XLEN-8){byte_sel[7]}}, byte_sel};
			MOP_LBU: load_data = {{(XLEN-8){1'b0}}, byte_sel};
			MOP_LH:  load_data = {{(XLEN-16){half_sel[15]}}, half_sel};
			MOP_LHU: load_data = {{(XLEN-16){1'b0}}, half_sel};
			// lwl lands in the upper lanes, 3-k..3
			MOP_LWL: begin
				load_data = memdata_i << {~k, 3'b000};
				load_wren = {LANES{1'b1}} << ~k;
			end
			// lwr lands in the lower lanes, 0..3-k
			MOP_LWR: begin
				load_data = memdata_i >> {k, 3'b000};
				load_wren = {LANES{1'b1}} >> k;
			end
			default: ;
		endcase
	end

	// writeback select: c0 first, then load, then ALU
	always_comb begin
		wdata_next = mem_wdata_i;
		if (ld) begin
			wdata_next = load_data;
		end
		if (mem_c0_ren_i) begin
			wdata_next = mem_c0data_i;
		end
	end

	assign wren_next = ld ? load_wren : mem_wren_i;

	// forwarding taps straight off EX/MEM
	assign mem_wdata_bp_o = mem_wdata_i;
	assign mem_nofwd_bp_o = mem_nofwd_i;

	// MEM/WB boundary; pc survives a flush
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			wb_inst_o   <= '0;
			wb_inslot_o <= 1'b0;
			wb_is_mem_o <= 1'b0;
			wb_waddr_o  <= '0;
			wb_wdata_o  <= '0;
			wb_wren_o   <= '0;
			wb_pc_o     <= '0;
		end else if (!stall_i) begin
			wb_pc_o <= mem_pc_i;
			if (flush_i) begin
				wb_inst_o   <= '0;
				wb_inslot_o <= 1'b0;
				wb_is_mem_o <= 1'b0;
				wb_waddr_o  <= '0;
				wb_wdata_o  <= '0;
				wb_wren_o   <= '0;
			end else begin
				wb_inst_o   <= mem_inst_i;
				wb_inslot_o <= mem_inslot_i;
				wb_is_mem_o <= ld | is_store(mem_memop_i);
				wb_waddr_o  <= mem_waddr_i;
				wb_wdata_o  <= wdata_next;
				wb_wren_o   <= wren_next;
			end
		end
	end

endmodule

// ==== mem_subsystem.sv ====
`timescale 1ns/1ps

module mem_subsystem #(
	parameter int DMEM_AW = 8
) (
	input  logic                             clk,
	input  logic                             rst_n_i,
	input  logic                             stall_i,
	input  logic                             flush_i,
	input  mips_mem_pkg::memop_e             ex_memop_i,
	input  logic [mips_pipe_pkg::XLEN-1:0]   ex_addr_i,
	input  logic [mips_pipe_pkg::XLEN-1:0]   ex_store_data_i,
	input  logic [mips_pipe_pkg::XLEN-1:0]   ex_inst_i,
	input  logic [mips_pipe_pkg::XLEN-1:0]   ex_pc_i,
	input  logic                             ex_inslot_i,
	input  logic [mips_pipe_pkg::REG_AW-1:0] ex_waddr_i,
	input  logic [mips_pipe_pkg::XLEN-1:0]   ex_wdata_i,
	input  logic [mips_pipe_pkg::LANES-1:0]  ex_wren_i,
	input  logic                             ex_nofwd_i,
	input  logic                             ex_c0_ren_i,
	input  logic [mips_pipe_pkg::XLEN-1:0]   ex_c0data_i,
	output logic [mips_pipe_pkg::XLEN-1:0]   wb_inst_o,
	output logic                             wb_inslot_o,
	output logic                             wb_is_mem_o,
	output logic [mips_pipe_pkg::REG_AW-1:0] wb_waddr_o,
	output logic [mips_pipe_pkg::XLEN-1:0]   wb_wdata_o,
	output logic [mips_pipe_pkg::LANES-1:0]  wb_wren_o,
	output logic [mips_pipe_pkg::XLEN-1:0]   wb_pc_o,
	output logic [mips_pipe_pkg::XLEN-1:0]   mem_wdata_bp_o,
	output logic                             mem_nofwd_bp_o
);
	import mips_pipe_pkg::*;
	import mips_mem_pkg::*;

	// SRAM port
	logic               sram_en;
	logic [LANES-1:0]   sram_we;
	logic [DMEM_AW-1:0] sram_addr;
	logic [XLEN-1:0]    sram_wdata;
	logic [XLEN-1:0]    sram_rdata;

	// EX/MEM fields
	memop_e             memop;
	logic [1:0]         addr_low;
	logic [XLEN-1:0]    inst;
	logic [XLEN-1:0]    pc;
	logic               inslot;
	logic [REG_AW-1:0]  waddr;
	logic [XLEN-1:0]    wdata;
	logic [LANES-1:0]   wren;
	logic               nofwd;
	logic               c0_ren;
	logic [XLEN-1:0]    c0data;

	mem_access #(.DMEM_AW(DMEM_AW)) mem_access_inst (
		.clk(clk), .rst_n_i(rst_n_i), .stall_i(stall_i),
		.ex_memop_i(ex_memop_i), .ex_addr_i(ex_addr_i), .ex_store_data_i(ex_store_data_i),
		.ex_inst_i(ex_inst_i), .ex_pc_i(ex_pc_i), .ex_inslot_i(ex_inslot_i),
		.ex_waddr_i(ex_waddr_i), .ex_wdata_i(ex_wdata_i), .ex_wren_i(ex_wren_i),
		.ex_nofwd_i(ex_nofwd_i), .ex_c0_ren_i(ex_c0_ren_i), .ex_c0data_i(ex_c0data_i),
		.sram_en_o(sram_en), .sram_we_o(sram_we),
		.sram_addr_o(sram_addr), .sram_wdata_o(sram_wdata),
		.mem_memop_o(memop), .mem_addr_low_o(addr_low), .mem_inst_o(inst),
		.mem_pc_o(pc), .mem_inslot_o(inslot), .mem_waddr_o(waddr),
		.mem_wdata_o(wdata), .mem_wren_o(wren), .mem_nofwd_o(nofwd),
		.mem_c0_ren_o(c0_ren), .mem_c0data_o(c0data)
	);

	data_sram #(.DMEM_AW(DMEM_AW)) data_sram_inst (
		.clk(clk), .en_i(sram_en), .we_i(sram_we),
		.addr_i(sram_addr), .wdata_i(sram_wdata), .rdata_o(sram_rdata)
	);

	mem_stage mem_stage_inst (
		.clk(clk), .rst_n_i(rst_n_i), .stall_i(stall_i), .flush_i(flush_i),
		.memdata_i(sram_rdata),
		.mem_memop_i(memop), .mem_addr_low_i(addr_low), .mem_inst_i(inst),
		.mem_pc_i(pc), .mem_inslot_i(inslot), .mem_waddr_i(waddr),
		.mem_wdata_i(wdata), .mem_wren_i(wren), .mem_nofwd_i(nofwd),
		.mem_c0_ren_i(c0_ren), .mem_c0data_i(c0data),
		.wb_inst_o(wb_inst_o), .wb_inslot_o(wb_inslot_o), .wb_is_mem_o(wb_is_mem_o),
		.wb_waddr_o(wb_waddr_o), .wb_wdata_o(wb_wdata_o), .wb_wren_o(wb_wren_o),
		.wb_pc_o(wb_pc_o),
		.mem_wdata_bp_o(mem_wdata_bp_o), .mem_nofwd_bp_o(mem_nofwd_bp_o)
	);

endmodule

// ==== mem_subsystem_asserts.sv ====
`timescale 1ns/1ps

module mem_subsystem_asserts #(
	parameter int DMEM_AW = 8
) (
	input logic                             clk,
	input logic                             rst_n_i,
	input logic                             stall_i,
	input logic                             flush_i,
	input mips_mem_pkg::memop_e             ex_memop_i,
	input logic [mips_pipe_pkg::XLEN-1:0]   ex_addr_i,
	input logic [mips_pipe_pkg::XLEN-1:0]   ex_store_data_i,
	input logic [mips_pipe_pkg::XLEN-1:0]   ex_inst_i,
	input logic [mips_pipe_pkg::XLEN-1:0]   ex_pc_i,
	input logic                             ex_inslot_i,
	input logic [mips_pipe_pkg::REG_AW-1:0] ex_waddr_i,
	input logic [mips_pipe_pkg::XLEN-1:0]   ex_wdata_i,
	input logic [mips_pipe_pkg::LANES-1:0]  ex_wren_i,
	input logic                             ex_nofwd_i,
	input logic                             ex_c0_ren_i,
	input logic [mips_pipe_pkg::XLEN-1:0]   ex_c0data_i,
	input logic [mips_pipe_pkg::XLEN-1:0]   wb_inst_i,
	input logic                             wb_inslot_i,
	input logic                             wb_is_mem_i,
	input logic [mips_pipe_pkg::REG_AW-1:0] wb_waddr_i,
	input logic [mips_pipe_pkg::XLEN-1:0]   wb_wdata_i,
	input logic [mips_pipe_pkg::LANES-1:0]  wb_wren_i,
	input logic [mips_pipe_pkg::XLEN-1:0]   wb_pc_i,
	input logic [mips_pipe_pkg::XLEN-1:0]   bp_wdata_i,
	input logic                             bp_nofwd_i
);
	import mips_pipe_pkg::*;
	import mips_mem_pkg::*;

	localparam int DEPTH = 2 ** DMEM_AW;

	// byte-level store rules applied to the previous word
	function automatic logic [XLEN-1:0] store_merge(logic [XLEN-1:0] old, memop_e op, int k,
			logic [XLEN-1:0] d);
		logic [XLEN-1:0] w;
		logic [XLEN-1:0] left;
		logic [XLEN-1:0] right;
		w     = old;
		left  = d >> (8 * (3 - k));
		right = d << (8 * k);
		for (int n = 0; n < LANES; n++) begin
			case (op)
				MOP_SB:  if (n == k) w[8*n +: 8] = d[7:0];
				MOP_SH:  if (n >= k && n <= k + 1) w[8*n +: 8] = d[8*(n-k) +: 8];
				MOP_SW:  w[8*n +: 8] = d[8*n +: 8];
				MOP_SWL: if (n <= k) w[8*n +: 8] = left[8*n +: 8];
				MOP_SWR: if (n >= k) w[8*n +: 8] = right[8*n +: 8];
				default: ;
			endcase
		end
		return w;
	endfunction

	function automatic logic [XLEN-1:0] load_value(logic [XLEN-1:0] w, memop_e op, int k);
		logic [7:0]  b;
		logic [15:0] h;
		b = w[8*k +: 8];
		h = w[16*(k/2) +: 16];
		case (op)
			MOP_LB:  return {{24{b[7]}}, b};
			MOP_LBU: return {24'd0, b};
			MOP_LH:  return {{16{h[15]}}, h};
			MOP_LHU: return {16'd0, h};
			MOP_LWL: return w << (8 * (3 - k));
			MOP_LWR: return w >> (8 * k);
			default: return w;
		endcase
	endfunction

	// lanes that a load hands to writeback
	function automatic logic [LANES-1:0] load_mask(memop_e op, int k);
		logic [LANES-1:0] m;
		for (int n = 0; n < LANES; n++) begin
			case (op)
				MOP_LWL: m[n] = (n >= 3 - k);
				MOP_LWR: m[n] = (n <= 3 - k);
				default: m[n] = 1'b1;
			endcase
		end
		return m;
	endfunction

	logic [XLEN-1:0]    shadow [DEPTH];
	logic [DMEM_AW-1:0] idx;
	int                 k;
	logic [XLEN-1:0]    word;
	logic               ld;
	logic               st;
	logic [XLEN-1:0]    exp_data;
	logic [LANES-1:0]   exp_wren;
	logic               rst_seen = 1'b0;
	int                 fail_count = 0;
	int                 checks_done = 0;

	// r0 mirrors EX/MEM, r1 mirrors MEM/WB
	logic               r0_valid;
	logic [XLEN-1:0]    r0_pc;
	logic [XLEN-1:0]    r0_inst;
	logic               r0_inslot;
	logic               r0_is_mem;
	logic [REG_AW-1:0]  r0_waddr;
	logic [XLEN-1:0]    r0_data;
	logic [LANES-1:0]   r0_wren;
	logic [XLEN-1:0]    r0_bp_wdata;
	logic               r0_nofwd;
	logic               r1_valid;
	logic [XLEN-1:0]    r1_pc;
	logic [XLEN-1:0]    r1_inst;
	logic               r1_inslot;
	logic               r1_is_mem;
	logic [REG_AW-1:0]  r1_waddr;
	logic [XLEN-1:0]    r1_data;
	logic [LANES-1:0]   r1_wren;

	always_comb begin
		idx      = ex_addr_i[2 +: DMEM_AW];
		k        = int'(ex_addr_i[1:0]);
		word     = shadow[idx];
		ld       = ex_memop_i inside {MOP_LB, MOP_LBU, MOP_LH, MOP_LHU, MOP_LW, MOP_LWL, MOP_LWR};
		st       = ex_memop_i inside {MOP_SB, MOP_SH, MOP_SW, MOP_SWL, MOP_SWR};
		exp_data = ld ? load_value(word, ex_memop_i, k) : ex_wdata_i;
		if (ex_c0_ren_i) begin
			exp_data = ex_c0data_i;
		end
		exp_wren = ld ? load_mask(ex_memop_i, k) : ex_wren_i;
	end

	always @(posedge clk) begin
		rst_seen <= !rst_n_i;
		if (r1_valid) begin
			checks_done <= checks_done + 1;
		end
		if (!rst_n_i) begin
			r0_valid <= 1'b0;
			r1_valid <= 1'b0;
		end else if (!stall_i) begin
			if (st) begin
				shadow[idx] <= store_merge(word, ex_memop_i, k, ex_store_data_i);
			end
			r0_valid    <= 1'b1;
			r0_pc       <= ex_pc_i;
			r0_inst     <= ex_inst_i;
			r0_inslot   <= ex_inslot_i;
			r0_is_mem   <= ld | st;
			r0_waddr    <= ex_waddr_i;
			r0_data     <= exp_data;
			r0_wren     <= exp_wren;
			r0_bp_wdata <= ex_wdata_i;
			r0_nofwd    <= ex_nofwd_i;
			// a flushed entry keeps only its pc
			r1_valid    <= r0_valid;
			r1_pc       <= r0_pc;
			r1_inst     <= flush_i ? '0 : r0_inst;
			r1_inslot   <= flush_i ? 1'b0 : r0_inslot;
			r1_is_mem   <= flush_i ? 1'b0 : r0_is_mem;
			r1_waddr    <= flush_i ? '0 : r0_waddr;
			r1_data     <= flush_i ? '0 : r0_data;
			r1_wren     <= flush_i ? '0 : r0_wren;
		end
	end

	a_wb_wdata: assert property (@(posedge clk) disable iff (!rst_n_i)
		r1_valid |-> wb_wdata_i == r1_data)
		else begin
			fail_count++;
			$error("mismatch wb_wdata: expected %h actual %h", $sampled(r1_data),
				$sampled(wb_wdata_i));
		end

	a_wb_wren: assert property (@(posedge clk) disable iff (!rst_n_i)
		r1_valid |-> wb_wren_i == r1_wren)
		else begin
			fail_count++;
			$error("mismatch wb_wren: expected %b actual %b", $sampled(r1_wren),
				$sampled(wb_wren_i));
		end

	// pc, waddr, inst, inslot and is_mem checked as one field group
	a_wb_fields: assert property (@(posedge clk) disable iff (!rst_n_i)
		r1_valid |-> {wb_pc_i, wb_waddr_i, wb_inst_i, wb_inslot_i, wb_is_mem_i}
			== {r1_pc, r1_waddr, r1_inst, r1_inslot, r1_is_mem})
		else begin
			fail_count++;
			$error("mismatch wb_fields: expected %h actual %h",
				$sampled({r1_pc, r1_waddr, r1_inst, r1_inslot, r1_is_mem}),
				$sampled({wb_pc_i, wb_waddr_i, wb_inst_i, wb_inslot_i, wb_is_mem_i}));
		end

	a_bypass: assert property (@(posedge clk) disable iff (!rst_n_i)
		r0_valid |-> {bp_wdata_i, bp_nofwd_i} == {r0_bp_wdata, r0_nofwd})
		else begin
			fail_count++;
			$error("mismatch bypass: expected %h actual %h", $sampled({r0_bp_wdata, r0_nofwd}),
				$sampled({bp_wdata_i, bp_nofwd_i}));
		end

	a_reset: assert property (@(posedge clk) rst_seen |-> wb_wren_i == '0 && wb_wdata_i == '0)
		else begin
			fail_count++;
			$error("writeback outputs were not cleared by reset");
		end

endmodule

bind mem_subsystem mem_subsystem_asserts #(.DMEM_AW(DMEM_AW)) mem_subsystem_asserts_inst (
	.clk(clk), .rst_n_i(rst_n_i), .stall_i(stall_i), .flush_i(flush_i),
	.ex_memop_i(ex_memop_i), .ex_addr_i(ex_addr_i), .ex_store_data_i(ex_store_data_i),
	.ex_inst_i(ex_inst_i), .ex_pc_i(ex_pc_i), .ex_inslot_i(ex_inslot_i),
	.ex_waddr_i(ex_waddr_i), .ex_wdata_i(ex_wdata_i), .ex_wren_i(ex_wren_i),
	.ex_nofwd_i(ex_nofwd_i), .ex_c0_ren_i(ex_c0_ren_i), .ex_c0data_i(ex_c0data_i),
	.wb_inst_i(wb_inst_o), .wb_inslot_i(wb_inslot_o), .wb_is_mem_i(wb_is_mem_o),
	.wb_waddr_i(wb_waddr_o), .wb_wdata_i(wb_wdata_o), .wb_wren_i(wb_wren_o),
	.wb_pc_i(wb_pc_o), .bp_wdata_i(mem_wdata_bp_o), .bp_nofwd_i(mem_nofwd_bp_o)
);

// ==== mips_mem_pkg.sv ====
package mips_mem_pkg;

	// memory opcodes carried from decode down to writeback
	typedef enum logic [3:0] {
		MOP_NONE = 4'd0,
		MOP_LB   = 4'd1,
		MOP_LBU  = 4'd2,
		MOP_LH   = 4'd3,
		MOP_LHU  = 4'd4,
		MOP_LW   = 4'd5,
		MOP_LWL  = 4'd6,
		MOP_LWR  = 4'd7,
		MOP_SB   = 4'd8,
		MOP_SH   = 4'd9,
		MOP_SW   = 4'd10,
		MOP_SWL  = 4'd11,
		MOP_SWR  = 4'd12
	} memop_e;

	// any opcode that returns data from the SRAM
	function automatic logic is_load(memop_e op);
		return op inside {MOP_LB, MOP_LBU, MOP_LH, MOP_LHU, MOP_LW, MOP_LWL, MOP_LWR};
	endfunction

	// any opcode that writes bytes into the SRAM
	function automatic logic is_store(memop_e op);
		return op inside {MOP_SB, MOP_SH, MOP_SW, MOP_SWL, MOP_SWR};
	endfunction

endpackage

// ==== mips_pipe_pkg.sv ====
package mips_pipe_pkg;

	// datapath and program counter width
	parameter int XLEN = 32;

	// register file address width, 32 GPRs
	parameter int REG_AW = 5;

	// byte lanes per word
	parameter int LANES = XLEN / 8;

	// width of one byte lane
	parameter int BYTE_W = 8;

	// low address bits that select a lane inside a word
	parameter int ADDR_LSB = $clog2(LANES);

endpackage

// ==== tb_mem_subsystem.sv ====
`timescale 1ns/1ps

module tb_mem_subsystem;
	import mips_pipe_pkg::*;
	import mips_mem_pkg::*;

	localparam int DMEM_AW = 8;

	logic               clk = 1'b0;
	logic               rst_n_i;
	logic               stall_i;
	logic               flush_i;
	memop_e             ex_memop_i;
	logic [XLEN-1:0]    ex_addr_i;
	logic [XLEN-1:0]    ex_store_data_i;
	logic [XLEN-1:0]    ex_inst_i;
	logic [XLEN-1:0]    ex_pc_i;
	logic               ex_inslot_i;
	logic [REG_AW-1:0]  ex_waddr_i;
	logic [XLEN-1:0]    ex_wdata_i;
	logic [LANES-1:0]   ex_wren_i;
	logic               ex_nofwd_i;
	logic               ex_c0_ren_i;
	logic [XLEN-1:0]    ex_c0data_i;
	logic [XLEN-1:0]    wb_inst_o;
	logic               wb_inslot_o;
	logic               wb_is_mem_o;
	logic [REG_AW-1:0]  wb_waddr_o;
	logic [XLEN-1:0]    wb_wdata_o;
	logic [LANES-1:0]   wb_wren_o;
	logic [XLEN-1:0]    wb_pc_o;
	logic [XLEN-1:0]    mem_wdata_bp_o;
	logic               mem_nofwd_bp_o;

	integer             seed;
	logic [XLEN-1:0]    pc_next;
	logic [XLEN-1:0]    rnd;
	int                 timeouts;
	int                 fails;
	int                 checks;

	mem_subsystem #(.DMEM_AW(DMEM_AW)) mem_subsystem_inst (
		.clk(clk), .rst_n_i(rst_n_i), .stall_i(stall_i), .flush_i(flush_i),
		.ex_memop_i(ex_memop_i), .ex_addr_i(ex_addr_i), .ex_store_data_i(ex_store_data_i),
		.ex_inst_i(ex_inst_i), .ex_pc_i(ex_pc_i), .ex_inslot_i(ex_inslot_i),
		.ex_waddr_i(ex_waddr_i), .ex_wdata_i(ex_wdata_i), .ex_wren_i(ex_wren_i),
		.ex_nofwd_i(ex_nofwd_i), .ex_c0_ren_i(ex_c0_ren_i), .ex_c0data_i(ex_c0data_i),
		.wb_inst_o(wb_inst_o), .wb_inslot_o(wb_inslot_o), .wb_is_mem_o(wb_is_mem_o),
		.wb_waddr_o(wb_waddr_o), .wb_wdata_o(wb_wdata_o), .wb_wren_o(wb_wren_o),
		.wb_pc_o(wb_pc_o), .mem_wdata_bp_o(mem_wdata_bp_o), .mem_nofwd_bp_o(mem_nofwd_bp_o)
	);

	always #4 clk = ~clk;

	// one request in EX for one cycle; fields outside the access are random
	task automatic send(memop_e op, logic [XLEN-1:0] addr, logic [XLEN-1:0] sdata, logic c0,
			logic fl);
		logic [XLEN-1:0] r;
		@(posedge clk);
		#1;
		ex_memop_i      = op;
		ex_addr_i       = addr;
		ex_store_data_i = sdata;
		ex_c0_ren_i     = c0;
		flush_i         = fl;
		ex_pc_i         = pc_next;
		pc_next         = pc_next + 4;
		ex_inst_i       = $random(seed);
		ex_wdata_i      = $random(seed);
		ex_c0data_i     = $random(seed);
		r               = $random(seed);
		ex_waddr_i      = r[4:0];
		ex_wren_i       = r[8:5];
		ex_inslot_i     = r[9];
		ex_nofwd_i      = r[10];
	endtask

	// plain ALU instructions
	task automatic idle(int n);
		for (int i = 0; i < n; i++) begin
			send(MOP_NONE, '0, '0, 1'b0, 1'b0);
		end
	endtask

	// the request in EX is captured and then the pipe freezes for n edges
	task automatic stall_for(int n);
		@(posedge clk);
		#1;
		stall_i = 1'b1;
		// a different load waits in EX while the pipe is frozen
		ex_addr_i  = ex_addr_i ^ 32'h4;
		ex_pc_i    = pc_next;
		pc_next    = pc_next + 4;
		ex_wdata_i = $random(seed);
		repeat (n) @(posedge clk);
		#1;
		stall_i    = 1'b0;
		ex_memop_i = MOP_NONE;
	endtask

	task automatic wait_wb_mem(logic level, int limit);
		int i;
		for (i = 0; i < limit; i++) begin
			@(posedge clk);
			#1;
			if (wb_is_mem_o == level) begin
				break;
			end
		end
		if (i == limit) begin
			timeouts++;
			$display("timeout waiting for wb_is_mem_o to reach %0b after %0d cycles", level, limit);
		end
	endtask

	initial begin
		seed            = 32'hb760_32c1;
		rst_n_i         = 1'b0;
		stall_i         = 1'b0;
		flush_i         = 1'b0;
		ex_memop_i      = MOP_NONE;
		ex_addr_i       = '0;
		ex_store_data_i = '0;
		ex_inst_i       = '0;
		ex_pc_i         = '0;
		ex_inslot_i     = 1'b0;
		ex_waddr_i      = '0;
		ex_wdata_i      = '0;
		ex_wren_i       = '0;
		ex_nofwd_i      = 1'b0;
		ex_c0_ren_i     = 1'b0;
		ex_c0data_i     = '0;
		pc_next         = 32'h0040_0000;
		timeouts        = 0;
		repeat (8) @(posedge clk);
		#1;
		rst_n_i = 1'b1;

		// whole words stored and read back
		for (int i = 0; i < 6; i++) begin
			send(MOP_SW, 32'h100 + 4 * i, $random(seed), 1'b0, 1'b0);
		end
		for (int i = 0; i < 6; i++) begin
			send(MOP_LW, 32'h100 + 4 * i, '0, 1'b0, 1'b0);
		end

		// byte stores with the sign bit alternating per offset
		for (int k = 0; k < 4; k++) begin
			send(MOP_SW, 32'h200, $random(seed), 1'b0, 1'b0);
			rnd    = $random(seed);
			rnd[7] = k[0];
			send(MOP_SB, 32'h200 + k, rnd, 1'b0, 1'b0);
			send(MOP_LB, 32'h200 + k, '0, 1'b0, 1'b0);
			send(MOP_LBU, 32'h200 + k, '0, 1'b0, 1'b0);
			send(MOP_LW, 32'h200, '0, 1'b0, 1'b0);
		end

		for (int k = 0; k < 4; k += 2) begin
			send(MOP_SW, 32'h300, $random(seed), 1'b0, 1'b0);
			rnd     = $random(seed);
			rnd[15] = k[1];
			send(MOP_SH, 32'h300 + k, rnd, 1'b0, 1'b0);
			send(MOP_LH, 32'h300 + k, '0, 1'b0, 1'b0);
			send(MOP_LHU, 32'h300 + k, '0, 1'b0, 1'b0);
			send(MOP_LW, 32'h300, '0, 1'b0, 1'b0);
		end

		// unaligned stores and loads at every offset
		for (int k = 0; k < 4; k++) begin
			send(MOP_SW, 32'h340, $random(seed), 1'b0, 1'b0);
			send(MOP_SWL, 32'h340 + k, $random(seed), 1'b0, 1'b0);
			send(MOP_LW, 32'h340, '0, 1'b0, 1'b0);
			send(MOP_SW, 32'h344, $random(seed), 1'b0, 1'b0);
			send(MOP_SWR, 32'h344 + k, $random(seed), 1'b0, 1'b0);
			send(MOP_LW, 32'h344, '0, 1'b0, 1'b0);
		end
		send(MOP_SW, 32'h380, $random(seed), 1'b0, 1'b0);
		for (int k = 0; k < 4; k++) begin
			send(MOP_LWL, 32'h380 + k, '0, 1'b0, 1'b0);
			send(MOP_LWR, 32'h380 + k, '0, 1'b0, 1'b0);
		end

		// load held by a stall and then a flushed load
		idle(2);
		send(MOP_LW, 32'h108, '0, 1'b0, 1'b0);
		stall_for(5);
		wait_wb_mem(1'b1, 8);
		send(MOP_LW, 32'h10c, '0, 1'b0, 1'b0);
		send(MOP_NONE, '0, '0, 1'b0, 1'b1);

		// coprocessor 0 read and ALU pass-through
		send(MOP_NONE, '0, '0, 1'b1, 1'b0);
		idle(4);
		wait_wb_mem(1'b0, 8);

		fails  = mem_subsystem_inst.mem_subsystem_asserts_inst.fail_count;
		checks = mem_subsystem_inst.mem_subsystem_asserts_inst.checks_done;
		if (checks == 0) begin
			$display("no writeback checks were evaluated");
		end
		$display("assertion failures %0d, timeouts %0d, writeback checks %0d",
			fails, timeouts, checks);
		if (fails == 0 && timeouts == 0 && checks > 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
mips_pipe_pkg.sv
mips_mem_pkg.sv
mem_access.sv
data_sram.sv
mem_stage.sv
mem_subsystem.sv
mem_subsystem_asserts.sv
tb_mem_subsystem.sv
